/* Makefile */
# Verilator flow for the enqueue descriptor path testbench.
# Run from the project root, the testbench reads its data file from sim/.

VERILATOR ?= verilator
TOP ?= tb_enq_pkt_desc
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
SIMFLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and pass only if the testbench passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
src/meta_package.sv
src/sfifo_ram_enq_pkt_desc.sv
src/sfifo_enq_pkt_desc.sv
src/sfifo_ram_pf_enq_pkt_desc.sv
src/enq_desc_builder.sv
src/enq_desc_dispatch.sv
src/enq_pkt_desc_top.sv
sim/enq_pkt_desc_assertions.sv
sim/tb_enq_pkt_desc.sv

/* sim/enq_pkt_desc_assertions.sv */
// ==========================================================
// fifo rules bound into the prefetch fifo.
// wr and full belong to the two-entry head stage.
// checks are off while rst_n is low.
// ==========================================================

`timescale 1ns/1ps

module enq_pkt_desc_assertions #(
	parameter int DEPTH_NBITS = meta_package::FIFO_DEPTH_NBITS
) (
	input  logic clk,
	input  logic rst_n,
	input  logic wr,
	input  logic rd,
	input  logic full,
	input  logic empty,
	input  logic [DEPTH_NBITS:0] count
);

	// number of assertion failures so far.
	int fail_count = 0;

	// the prefetch must never write into a full head stage.
	no_wr_while_full: assert property (@(posedge clk) disable iff (!rst_n) !(wr && full))
		else begin
			$error("head stage written while full");
			fail_count++;
		end

	// the dispatch stage must never pop an empty fifo.
	no_rd_while_empty: assert property (@(posedge clk) disable iff (!rst_n) !(rd && empty))
		else begin
			$error("fifo read while empty");
			fail_count++;
		end

	// ram entries plus the two head registers.
	count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		count <= (2**DEPTH_NBITS + 2))
		else begin
			$error("fifo count above capacity");
			fail_count++;
		end

endmodule

/* sim/enq_pkt_desc_tests.txt */
// one packet per line, hex: qid, words, last word bytes, hold cycles after,
// words sent before a restarting sop, times the line is repeated.
0 1 8 0 0 1
1 3 5 0 0 1
2 2 1 0 0 1
3 4 8 0 0 2
0 10 7 0 0 1
// oversize packet, 9680 bytes, saturates with err set.
1 4ba 8 0 0 1
// two abandoned words, then a restarting sop.
2 3 3 0 2 1
3 1 6 0 1 1
0 1 4 0 0 3
// 20 packets with deq_hold high, the last two are dropped.
1 2 6 3 0 14
3 2 7 0 0 2
2 5 2 0 0 1
0 3 8 2 0 2
1 1 1 0 0 1

/* sim/tb_enq_pkt_desc.sv */
// ==========================================================
// testbench for the enqueue descriptor path.
// packets come from sim/enq_pkt_desc_tests.txt under the root.
// hold runs start from an empty fifo so the drop point is known.
// ==========================================================

`timescale 1ns/1ps

module tb_enq_pkt_desc;

	import meta_package::*;

	localparam int CAPACITY = 2**FIFO_DEPTH_NBITS + 2;
	localparam int NUM_FIELDS = 6;
	localparam int MAX_ENTRIES = 256;
	localparam int DRAIN_LIMIT = 400;

	logic clk;
	logic rst_n;
	logic pkt_word;
	logic sop;
	logic eop;
	logic [3:0] word_bytes;
	logic [1:0] qid;
	logic deq_hold;
	enq_pkt_desc_type desc_out;
	logic desc_valid;
	q_total_type q_total;
	logic [FIFO_DEPTH_NBITS:0] fifo_count;
	logic [15:0] drop_count;

	// raw data file words with 16'hffff marking the end.
	logic [15:0] tests [MAX_ENTRIES];

	// reference model state.
	enq_pkt_desc_type exp_q [$];
	int exp_total [NUM_QUEUES];
	logic [PTR_NBITS-1:0] exp_ptr;
	int exp_drops;
	int hold_accepted;
	int value_errors;
	int other_errors;
	int unsigned lcg_state;

	enq_pkt_desc_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.pkt_word(pkt_word),
		.sop(sop),
		.eop(eop),
		.word_bytes(word_bytes),
		.qid(qid),
		.deq_hold(deq_hold),
		.desc_out(desc_out),
		.desc_valid(desc_valid),
		.q_total(q_total),
		.fifo_count(fifo_count),
		.drop_count(drop_count)
	);

	bind sfifo_ram_pf_enq_pkt_desc enq_pkt_desc_assertions #(
		.DEPTH_NBITS(DEPTH_NBITS)
	) u_fifo_assertions (
		.clk(clk),
		.rst_n(rst_n),
		.wr(prefetch_fifo_wr),
		.rd(rd),
		.full(prefetch_fifo_full),
		.empty(empty),
		.count(count)
	);

	always #5 clk = ~clk;

	// gap lengths between packets.
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	task automatic check_value(input string name, input logic [95:0] got,
		input logic [95:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// drives one word and waits for the next falling edge.
	task automatic drive_word(input logic [1:0] q, input logic s, input logic e,
		input logic [3:0] nbytes);
		pkt_word = 1'b1;
		sop = s;
		eop = e;
		word_bytes = nbytes;
		qid = q;
		@(negedge clk);
	endtask

	task automatic idle_cycles(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			@(negedge clk);
		end
	endtask

	// abandoned words use another qid so the restart must drop them.
	task automatic send_packet(input logic [1:0] q, input int words, input int last_bytes,
		input int restart_words);
		int i;
		for (i = 0; i < restart_words; i++) begin
			drive_word(q ^ 2'b01, i == 0, 1'b0, WORD_BYTES);
		end
		for (i = 0; i < words; i++) begin
			drive_word(q, i == 0, i == words - 1,
				(i == words - 1) ? 4'(last_bytes) : WORD_BYTES);
		end
		pkt_word = 1'b0;
		sop = 1'b0;
		eop = 1'b0;
	endtask

	// predicts a descriptor or a drop once a hold run has filled the fifo.
	task automatic expect_packet(input logic [1:0] q, input int words, input int last_bytes);
		int len;
		enq_pkt_desc_type desc;
		len = (words - 1) * int'(WORD_BYTES) + last_bytes;
		desc.qid = q;
		desc.err = (len > int'(MAX_PKT_LEN));
		desc.len = desc.err ? MAX_PKT_LEN : LEN_NBITS'(len);
		desc.buf_ptr = exp_ptr;
		if (deq_hold && hold_accepted == CAPACITY) begin
			exp_drops++;
		end else begin
			exp_q.push_back(desc);
			exp_ptr = exp_ptr + 1'b1;
			if (deq_hold) begin
				hold_accepted++;
			end
			if (!desc.err) begin
				exp_total[q] += len;
			end
		end
	endtask

	// release the dispatch stage and wait for every expected descriptor.
	task automatic drain_queue();
		int cycles;
		cycles = 0;
		deq_hold = 1'b0;
		while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d expected descriptors never left the DUT", exp_q.size());
			other_errors++;
			exp_q.delete();
		end
	endtask

	// every change of deq_hold starts from an empty fifo.
	task automatic set_hold(input logic level);
		if (level != deq_hold) begin
			drain_queue();
			deq_hold = level;
			hold_accepted = 0;
		end
	endtask

	// outputs are stable at the falling edge.
	always @(negedge clk) begin
		enq_pkt_desc_type exp_desc;
		if (rst_n && desc_valid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected descriptor at %0t ns with none outstanding", $time);
				other_errors++;
			end else begin
				exp_desc = exp_q.pop_front();
				check_value("desc_out.qid", 96'(desc_out.qid), 96'(exp_desc.qid));
				check_value("desc_out.len", 96'(desc_out.len), 96'(exp_desc.len));
				check_value("desc_out.buf_ptr", 96'(desc_out.buf_ptr), 96'(exp_desc.buf_ptr));
				check_value("desc_out.err", 96'(desc_out.err), 96'(exp_desc.err));
			end
		end
	end

	initial begin
		int idx;
		int q;
		int words;
		int last_bytes;
		int hold;
		int restart;
		int rep;
		int r;
		int i;
		clk = 1'b0;
		rst_n = 1'b0;
		pkt_word = 1'b0;
		sop = 1'b0;
		eop = 1'b0;
		word_bytes = '0;
		qid = '0;
		deq_hold = 1'b0;
		exp_ptr = '0;
		exp_drops = 0;
		hold_accepted = 0;
		value_errors = 0;
		other_errors = 0;
		lcg_state = 86;
		for (i = 0; i < NUM_QUEUES; i++) begin
			exp_total[i] = 0;
		end
		for (i = 0; i < MAX_ENTRIES; i++) begin
			tests[i] = 16'hffff;
		end
		$readmemh("sim/enq_pkt_desc_tests.txt", tests);
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		// idle state after reset.
		check_value("desc_valid", 96'(desc_valid), 96'(0));
		check_value("q_total", 96'(q_total), 96'(0));
		check_value("fifo_count", 96'(fifo_count), 96'(0));
		check_value("drop_count", 96'(drop_count), 96'(0));
		idle_cycles(8);
		idx = 0;
		while (idx <= MAX_ENTRIES - NUM_FIELDS && tests[idx] != 16'hffff) begin
			q = int'(tests[idx]);
			words = int'(tests[idx + 1]);
			last_bytes = int'(tests[idx + 2]);
			hold = int'(tests[idx + 3]);
			restart = int'(tests[idx + 4]);
			rep = int'(tests[idx + 5]);
			for (r = 0; r < rep; r++) begin
				set_hold(hold != 0);
				send_packet(2'(q), words, last_bytes, restart);
				expect_packet(2'(q), words, last_bytes);
				idle_cycles(hold + 1 + int'(lcg_next() % 4));
				// nothing leaves the fifo while held.
				if (deq_hold) begin
					check_value("fifo_count", 96'(fifo_count), 96'(hold_accepted));
					check_value("drop_count", 96'(drop_count), 96'(exp_drops));
				end
			end
			idx += NUM_FIELDS;
		end
		drain_queue();
		idle_cycles(4);
		for (i = 0; i < NUM_QUEUES; i++) begin
			check_value($sformatf("q_total[%0d]", i), 96'(q_total[i]), 96'(exp_total[i]));
		end
		check_value("drop_count", 96'(drop_count), 96'(exp_drops));
		check_value("fifo_count", 96'(fifo_count), 96'(0));
		other_errors += u_dut.u_sfifo_ram_pf_enq_pkt_desc.u_fifo_assertions.fail_count;
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* src/enq_desc_builder.sv */
// ==========================================================
// builds one descriptor per packet, written a cycle after eop.
// a packet seen while full is dropped and counted.
// words above WORD_BYTES bytes are counted as WORD_BYTES.
// ==========================================================

`timescale 1ns/1ps

module enq_desc_builder (
	input  logic clk,
	input  logic rst_n,
	input  logic pkt_word,
	input  logic sop,
	input  logic eop,
	input  logic [3:0] word_bytes,
	input  logic [1:0] qid,
	input  logic full,
	output meta_package::enq_pkt_desc_type din,
	output logic wr,
	output logic [15:0] drop_count
);

	import meta_package::*;

	builder_state_type state;

	// running length of the current packet.
	logic [LEN_NBITS-1:0] len_acc;
	logic len_over;
	logic [QID_NBITS-1:0] pkt_qid;

	logic [3:0] bytes_clamped;
	logic [LEN_NBITS:0] len_sum;
	logic [LEN_NBITS-1:0] len_next;
	logic over_next;
	logic word_take;
	logic capture;

	// descriptor waiting for its write cycle.
	logic pend;
	logic [QID_NBITS-1:0] pend_qid;
	logic [LEN_NBITS-1:0] pend_len;
	logic pend_err;
	logic [PTR_NBITS-1:0] next_ptr;

	assign bytes_clamped = (word_bytes > WORD_BYTES) ? WORD_BYTES : word_bytes;

	// words outside a packet are ignored.
	assign word_take = pkt_word & (sop | (state == IN_PKT));
	assign capture = word_take & eop;

	// a sop restarts the count from zero.
	assign len_sum = (sop ? '0 : {1'b0, len_acc}) +
		{{(LEN_NBITS-3){1'b0}}, bytes_clamped};
	assign over_next = (~sop & len_over) | (len_sum > {1'b0, MAX_PKT_LEN});
	// saturate at the maximum once oversize.
	assign len_next = over_next ? MAX_PKT_LEN : len_sum[LEN_NBITS-1:0];

	// write only when there is room.
	assign wr = pend & ~full;
	assign din = '{qid: pend_qid, len: pend_len, buf_ptr: next_ptr, err: pend_err};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			pend <= 1'b0;
			next_ptr <= '0;
			drop_count <= '0;
		end else begin
			if (word_take) begin
				state <= eop ? IDLE : IN_PKT;
			end
			// single-cycle write request.
			pend <= capture;
			// pointer advances on accepted writes only.
			if (wr) begin
				next_ptr <= next_ptr + 1'b1;
			end
			if (pend && full) begin
				drop_count <= drop_count + 1'b1;
			end
		end
	end

	// length accumulation and descriptor capture.
	always_ff @(posedge clk) begin
		if (word_take) begin
			len_acc <= len_next;
			len_over <= over_next;
		end
		if (pkt_word && sop) begin
			pkt_qid <= qid;
		end
		if (capture) begin
			pend_qid <= sop ? qid : pkt_qid;
			pend_len <= len_next;
			pend_err <= over_next;
		end
	end

endmodule

/* src/enq_desc_dispatch.sv */
// ==========================================================
// pops the fifo head while not held and registers it out.
// desc_valid and the totals update the cycle after rd.
// descriptors with err set do not count toward the totals.
// ==========================================================

`timescale 1ns/1ps

module enq_desc_dispatch (
	input  logic clk,
	input  logic rst_n,
	input  logic deq_hold,
	input  logic empty,
	input  meta_package::enq_pkt_desc_type dout,
	output logic rd,
	output meta_package::enq_pkt_desc_type desc_out,
	output logic desc_valid,
	output meta_package::q_total_type q_total
);

	import meta_package::*;

	logic [TOTAL_NBITS-1:0] len_ext;
	logic add_len;

	// pop whenever a head exists and the outside allows it.
	assign rd = ~deq_hold & ~empty;

	// length widened to the total width.
	assign len_ext = {{(TOTAL_NBITS-LEN_NBITS){1'b0}}, dout.len};
	assign add_len = rd & ~dout.err;

	// valid strobe and per-queue byte totals.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			desc_valid <= 1'b0;
			q_total <= '0;
		end else begin
			desc_valid <= rd;
			if (add_len) begin
				q_total[dout.qid] <= q_total[dout.qid] + len_ext;
			end
		end
	end

	// output register, loaded on each pop.
	always_ff @(posedge clk) begin
		if (rd) begin
			desc_out <= dout;
		end
	end

endmodule

/* src/enq_pkt_desc_top.sv */
// ==========================================================
// enqueue descriptor path, builder to fifo to dispatch.
// eop to desc_valid is at least 5 cycles.
// the fifo holds 2**FIFO_DEPTH_NBITS + 2 descriptors.
// ==========================================================

`timescale 1ns/1ps

module enq_pkt_desc_top (
	input  logic clk,
	input  logic rst_n,
	input  logic pkt_word,
	input  logic sop,
	input  logic eop,
	input  logic [3:0] word_bytes,
	input  logic [1:0] qid,
	input  logic deq_hold,
	output meta_package::enq_pkt_desc_type desc_out,
	output logic desc_valid,
	output meta_package::q_total_type q_total,
	output logic [meta_package::FIFO_DEPTH_NBITS:0] fifo_count,
	output logic [15:0] drop_count
);

	import meta_package::*;

	enq_pkt_desc_type fifo_din;
	enq_pkt_desc_type fifo_dout;
	logic fifo_wr;
	logic fifo_rd;
	logic fifo_full;
	logic fifo_empty;

	// packet words to descriptors.
	enq_desc_builder u_enq_desc_builder (
		.clk(clk),
		.rst_n(rst_n),
		.pkt_word(pkt_word),
		.sop(sop),
		.eop(eop),
		.word_bytes(word_bytes),
		.qid(qid),
		.full(fifo_full),
		.din(fifo_din),
		.wr(fifo_wr),
		.drop_count(drop_count)
	);

	// show-ahead descriptor queue.
	sfifo_ram_pf_enq_pkt_desc #(
		.DEPTH_NBITS(FIFO_DEPTH_NBITS)
	) u_sfifo_ram_pf_enq_pkt_desc (
		.clk(clk),
		.rst_n(rst_n),
		.din(fifo_din),
		.rd(fifo_rd),
		.wr(fifo_wr),
		.count(fifo_count),
		.full(fifo_full),
		.empty(fifo_empty),
		.dout(fifo_dout)
	);

	// pop, output register and totals.
	enq_desc_dispatch u_enq_desc_dispatch (
		.clk(clk),
		.rst_n(rst_n),
		.deq_hold(deq_hold),
		.empty(fifo_empty),
		.dout(fifo_dout),
		.rd(fifo_rd),
		.desc_out(desc_out),
		.desc_valid(desc_valid),
		.q_total(q_total)
	);

endmodule

/* src/meta_package.sv */
// ==========================================================
// shared types and sizes of the enqueue descriptor path.
// lengths saturate at MAX_PKT_LEN, queue totals wrap silently.
// ==========================================================

package meta_package;

	// queue id width and queue count.
	localparam int QID_NBITS = 2;
	localparam int NUM_QUEUES = 4;

	// packet length in bytes.
	localparam int LEN_NBITS = 14;
	localparam logic [LEN_NBITS-1:0] MAX_PKT_LEN = 14'd9600;

	// bytes carried by one full data word.
	localparam logic [3:0] WORD_BYTES = 4'd8;

	// buffer pointer width.
	localparam int PTR_NBITS = 12;

	// ram fifo address width at the top level, 16 entries.
	localparam int FIFO_DEPTH_NBITS = 4;

	// width of one per-queue byte total.
	localparam int TOTAL_NBITS = 24;

	// one packet descriptor, 29 bits.
	typedef struct packed {
		logic [QID_NBITS-1:0] qid;
		logic [LEN_NBITS-1:0] len;
		logic [PTR_NBITS-1:0] buf_ptr;
		logic err;
	} enq_pkt_desc_type;

	// byte totals, index is the queue id.
	typedef logic [NUM_QUEUES-1:0][TOTAL_NBITS-1:0] q_total_type;

	// builder fsm states.
	typedef enum logic {
		IDLE,
		IN_PKT
	} builder_state_type;

endpackage

/* src/sfifo_enq_pkt_desc.sv */
// ==========================================================
// small register fifo of descriptors with a show-ahead head.
// dout is only meaningful while empty is low.
// fullm1 is high when exactly one entry is free.
// ==========================================================

`timescale 1ns/1ps

module sfifo_enq_pkt_desc #(
	parameter int DEPTH_NBITS = 1
) (
	input  logic clk,
	input  logic rst_n,
	input  meta_package::enq_pkt_desc_type din,
	input  logic rd,
	input  logic wr,
	output logic full,
	output logic fullm1,
	output logic empty,
	output meta_package::enq_pkt_desc_type dout
);

	import meta_package::*;

	// entry registers.
	enq_pkt_desc_type mem [2**DEPTH_NBITS];

	logic [DEPTH_NBITS-1:0] wptr;
	logic [DEPTH_NBITS-1:0] rptr;
	logic [DEPTH_NBITS:0] cnt;

	logic wr_en;
	logic rd_en;

	assign wr_en = wr & ~full;
	assign rd_en = rd & ~empty;

	// cnt never exceeds the depth, so its top bit alone flags full.
	assign full = cnt[DEPTH_NBITS];
	// depth minus one is all low bits set with the top bit clear.
	assign fullm1 = ~cnt[DEPTH_NBITS] & (&cnt[DEPTH_NBITS-1:0]);
	assign empty = (cnt == '0);

	// head is visible without a read cycle.
	assign dout = mem[rptr];

	// pointers and occupancy.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
			cnt <= '0;
		end else begin
			if (wr_en) begin
				wptr <= wptr + 1'b1;
			end
			if (rd_en) begin
				rptr <= rptr + 1'b1;
			end
			// simultaneous rd and wr leave cnt unchanged.
			if (wr_en && !rd_en) begin
				cnt <= cnt + 1'b1;
			end else if (rd_en && !wr_en) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// entry write.
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wptr] <= din;
		end
	end

endmodule

/* src/sfifo_ram_enq_pkt_desc.sv */
// ==========================================================
// ram fifo of descriptors, 2**DEPTH_NBITS entries.
// dout is registered and valid the cycle after rd.
// rd while empty and wr while full are ignored.
// ==========================================================

`timescale 1ns/1ps

module sfifo_ram_enq_pkt_desc #(
	parameter int DEPTH_NBITS = meta_package::FIFO_DEPTH_NBITS
) (
	input  logic clk,
	input  logic rst_n,
	input  meta_package::enq_pkt_desc_type din,
	input  logic rd,
	input  logic wr,
	output logic full,
	output logic empty,
	output meta_package::enq_pkt_desc_type dout
);

	import meta_package::*;

	// storage array.
	enq_pkt_desc_type mem [2**DEPTH_NBITS];

	// pointers carry one wrap bit above the address.
	logic [DEPTH_NBITS:0] wptr;
	logic [DEPTH_NBITS:0] rptr;

	logic wr_en;
	logic rd_en;

	// guarded strobes.
	assign wr_en = wr & ~full;
	assign rd_en = rd & ~empty;

	// equal pointers mean empty.
	assign empty = (wptr == rptr);

	// same address on opposite wraps means full.
	assign full = (wptr[DEPTH_NBITS] != rptr[DEPTH_NBITS]) &&
		(wptr[DEPTH_NBITS-1:0] == rptr[DEPTH_NBITS-1:0]);

	// pointer update.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (wr_en) begin
				wptr <= wptr + 1'b1;
			end
			if (rd_en) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	// write port.
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wptr[DEPTH_NBITS-1:0]] <= din;
		end
	end

	// registered read port, one cycle of latency.
	always_ff @(posedge clk) begin
		if (rd_en) begin
			dout <= mem[rptr[DEPTH_NBITS-1:0]];
		end
	end

endmodule

/* src/sfifo_ram_pf_enq_pkt_desc.sv */
// ==========================================================
// show-ahead descriptor fifo, a ram fifo feeding 2 registers.
// holds 2**DEPTH_NBITS + 2 entries, count is total occupancy.
// a write into an empty fifo shows at dout 3 cycles later.
// ==========================================================

`timescale 1ns/1ps

module sfifo_ram_pf_enq_pkt_desc #(
	parameter int DEPTH_NBITS = meta_package::FIFO_DEPTH_NBITS
) (
	input  logic clk,
	input  logic rst_n,
	input  meta_package::enq_pkt_desc_type din,
	input  logic rd,
	input  logic wr,
	output logic [DEPTH_NBITS:0] count,
	output logic full,
	output logic empty,
	output meta_package::enq_pkt_desc_type dout
);

	import meta_package::*;

	logic fifo_rd;
	logic fifo_rd_d1;
	logic fifo_empty;
	enq_pkt_desc_type fifo_dout;

	logic prefetch_fifo_wr;
	logic prefetch_fifo_full;
	logic prefetch_fifo_fullm1;

	// ram data is valid one cycle after the read.
	assign prefetch_fifo_wr = fifo_rd_d1;

	// prefetch unless the register fifo has no room for another entry.
	assign fifo_rd = ~fifo_empty &
		~((prefetch_fifo_wr & prefetch_fifo_fullm1) | prefetch_fifo_full);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fifo_rd_d1 <= 1'b0;
			count <= '0;
		end else begin
			fifo_rd_d1 <= fifo_rd;
			// total occupancy over both stages.
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// bulk storage, its full flag is the fifo full.
	sfifo_ram_enq_pkt_desc #(
		.DEPTH_NBITS(DEPTH_NBITS)
	) u_sfifo_ram_enq_pkt_desc (
		.clk(clk),
		.rst_n(rst_n),
		.din(din),
		.rd(fifo_rd),
		.wr(wr),
		.full(full),
		.empty(fifo_empty),
		.dout(fifo_dout)
	);

	// two-entry head stage.
	sfifo_enq_pkt_desc #(
		.DEPTH_NBITS(1)
	) u_sfifo_enq_pkt_desc (
		.clk(clk),
		.rst_n(rst_n),
		.din(fifo_dout),
		.rd(rd),
		.wr(prefetch_fifo_wr),
		.full(prefetch_fifo_full),
		.fullm1(prefetch_fifo_fullm1),
		.empty(empty),
		.dout(dout)
	);

endmodule
